// File: filelist.f
design/ecc_pkg.sv
design/info_place.sv
design/parity_gen.sv
design/enc_stage_2.sv
design/ecc_encoder_top.sv
dv/ecc_sva.sv
dv/ecc_checker.sv
dv/ecc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ecc_tb -f filelist.f -o ecc_sim
./obj_dir/ecc_sim +verilator+error+limit+100 | tee sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: dv/ecc_tb.sv
module ecc_tb;

    localparam int LIMIT = 3000; // tests take about 2300 cycles

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    logic [1:0]  in_mode;
    logic [25:0] in_info;
    logic        out_valid;
    logic [31:0] out_code;
    logic        mode_err;
    logic [2:0]  test_idx;
    int          pending;
    int          errors;
    int          seed;
    int          cycles;
    int          rnd;
    logic [25:0] base;
    logic [25:0] info;

    always #50 clk = ~clk;

    ecc_encoder_top ecc_encoder_top_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_mode   (in_mode),
        .in_info   (in_info),
        .out_valid (out_valid),
        .out_code  (out_code),
        .mode_err  (mode_err)
    );

    ecc_checker checker_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_mode   (in_mode),
        .in_info   (in_info),
        .out_valid (out_valid),
        .out_code  (out_code),
        .mode_err  (mode_err),
        .test_idx  (test_idx),
        .pending   (pending),
        .errors    (errors)
    );

    bind ecc_encoder_top ecc_sva ecc_sva_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_code  (out_code),
        .mode_err  (mode_err)
    );

    // inputs change 10 units after the rising edge
    task automatic drive_word(input logic v, input logic [1:0] m, input logic [25:0] w);
        @(posedge clk);
        #10;
        in_valid = v;
        in_mode  = m;
        in_info  = w;
    endtask

    task automatic next_test(input logic [2:0] idx);
        drive_word(1'b0, 2'b00, 26'd0);
        while (pending != 0) @(posedge clk); // let the pipeline empty
        @(posedge clk);
        #10;
        test_idx = idx;
        repeat (2) @(posedge clk);           // checker prints its line meanwhile
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: tests still running after %0d cycles", LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        seed     = 32'hd757009c;
        cycles   = 0;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_mode  = 2'b00;
        in_info  = '0;
        test_idx = 3'd0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        repeat (3) @(posedge clk);
        next_test(3'd1);
        for (int i = 0; i < 2000; i++) begin // valid and mode both random
            rnd = $random(seed);
            drive_word(rnd[0], 2'(rnd[31:1] % 3), 26'($random(seed)));
        end
        next_test(3'd2);
        for (int i = 0; i < 60; i++) begin   // zeros, ones and random words
            rnd  = $random(seed);
            info = (i % 3 == 0) ? '0 : (i % 3 == 1) ? '1 : 26'($random(seed));
            drive_word(1'b1, 2'(rnd[31:1] % 3), info);
        end
        next_test(3'd3);
        for (int i = 0; i < 100; i++) begin  // back to back burst
            rnd = $random(seed);
            drive_word(1'b1, 2'(rnd[31:1] % 3), 26'($random(seed)));
        end
        next_test(3'd4);
        for (int i = 0; i < 40; i++) begin   // reserved mode mixed with valid ones
            rnd = $random(seed);
            drive_word(1'b1, (i % 2 == 1) ? 2'b11 : 2'(rnd[31:1] % 3), 26'($random(seed)));
        end
        next_test(3'd5);
        for (int m = 0; m < 3; m++) begin
            base = 26'($random(seed));
            drive_word(1'b1, 2'(m), base);
            for (int k = 0; k < ((m == 0) ? 4 : (m == 1) ? 11 : 26); k++) begin
                drive_word(1'b1, 2'(m), base ^ (26'd1 << k)); // one info bit flipped
            end
        end
        next_test(3'd6);
        if (errors == 0 && ecc_encoder_top_i.ecc_sva_i.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: dv/ecc_checker.sv
module ecc_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [1:0]  in_mode,
    input  logic [25:0] in_info,
    input  logic        out_valid,
    input  logic [31:0] out_code,
    input  logic        mode_err,
    input  logic [2:0]  test_idx, // test being driven or 6 once all are done
    output int          pending,  // words still in the pipeline
    output int          errors
);

    typedef struct packed {
        logic [31:0] code;
        logic        err;
        logic [1:0]  mode;
        logic [2:0]  test;
        int          stamp; // negedge count when the input was seen
    } exp_t;

    exp_t        exp_q[$];
    exp_t        e;
    int          cyc;
    int          words_in;
    int          outs_total;
    int          outs_by_test[7];
    int          errs_by_test[7];
    logic        rst_q;
    logic [2:0]  idx_q;
    logic [31:0] base_code;       // first codeword of a mode in single_bit_distance
    logic [1:0]  base_mode;

    function automatic string test_name(input logic [2:0] t);
        case (t)
            3'd0:    return "reset_state";
            3'd1:    return "random_modes";
            3'd2:    return "even_weight";
            3'd3:    return "latency_and_back_to_back";
            3'd4:    return "reserved_mode";
            3'd5:    return "single_bit_distance";
            default: return "done";
        endcase
    endfunction

    // extended hamming codeword built straight from the column rule
    function automatic logic [31:0] model_code(input logic [1:0] mode, input logic [25:0] info);
        logic [31:0] cw;
        logic [4:0]  sigs [26];
        int          p;
        int          iw;
        int          n;
        cw = '0;
        if (mode == 2'b11) begin
            return cw; // reserved
        end
        p  = (mode == 2'b00) ? 4 : (mode == 2'b01) ? 5 : 6;
        iw = (mode == 2'b00) ? 4 : (mode == 2'b01) ? 11 : 26;
        n  = 0;
        // ascending list so info bit k gets the k-th smallest signature
        for (int v = 3; v < (1 << (p - 1)); v++) begin
            if ($countones(5'(v)) >= 2) begin
                sigs[n] = 5'(v);
                n++;
            end
        end
        for (int k = 0; k < iw; k++) begin
            cw[p + k] = info[k];
            for (int j = 0; j < p - 1; j++) begin
                if (sigs[k][j]) begin
                    cw[j] ^= info[k]; // parity j covers every info bit with sig bit j
                end
            end
        end
        cw[p - 1] = ^cw; // overall parity
        return cw;
    endfunction

    task automatic value_error(input logic [2:0] t, input string what,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        errors++;
        errs_by_test[t]++;
        $display("** Error %s: %s expected 'h%0h, actual 'h%0h", test_name(t), what, exp_v, act_v);
    endtask

    task automatic plain_error(input logic [2:0] t, input string msg);
        errors++;
        errs_by_test[t]++;
        $display("%s: %s", test_name(t), msg);
    endtask

    initial begin
        cyc        = 0;
        words_in   = 0;
        outs_total = 0;
        pending    = 0;
        errors     = 0;
        rst_q      = 1'b0;
        idx_q      = 3'd0;
        base_code  = '0;
        base_mode  = 2'b11; // no base yet
        foreach (outs_by_test[i]) begin
            outs_by_test[i] = 0;
            errs_by_test[i] = 0;
        end
    end

    // sampled at negedge where inputs and outputs have settled
    always @(negedge clk) begin
        cyc++;
        if (rst || rst_q) begin // in reset and the cycle right after
            if (out_code !== '0) value_error(test_idx, "out_code in reset", '0, out_code);
            if ({out_valid, mode_err} !== 2'b00) begin
                plain_error(test_idx, "out_valid or mode_err not low in reset");
            end
        end
        rst_q = rst;
        if (!rst && in_valid === 1'b1) begin
            e.code  = model_code(in_mode, in_info);
            e.err   = (in_mode == 2'b11);
            e.mode  = in_mode;
            e.test  = test_idx;
            e.stamp = cyc;
            exp_q.push_back(e);
            words_in++;
        end
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                outs_total++;
                outs_by_test[test_idx]++; // stray pulse still counts toward the burst total
                plain_error(test_idx, "out_valid high with no word in flight");
            end else begin
                e = exp_q.pop_front();
                outs_total++;
                outs_by_test[e.test]++;
                if (cyc - e.stamp != 3) begin
                    plain_error(e.test, $sformatf("output came %0d cycles after its input, not 3",
                                                  cyc - e.stamp));
                end
                if (out_code !== e.code) value_error(e.test, "out_code", e.code, out_code);
                if (mode_err !== e.err) value_error(e.test, "mode_err", 32'(e.err), 32'(mode_err));
                // overall parity makes any valid codeword even
                if (!e.err && $countones(out_code) % 2 != 0) begin
                    plain_error(e.test, $sformatf("codeword 'h%0h has odd weight", out_code));
                end
                if (e.test == 3'd5) begin
                    if (e.mode != base_mode) begin
                        base_code = out_code; // unflipped word of this mode
                        base_mode = e.mode;
                    end else if ($countones(base_code ^ out_code) < 4) begin
                        plain_error(e.test, $sformatf("'h%0h and 'h%0h differ in under 4 bits",
                                                      base_code, out_code));
                    end
                end
            end
        end else if (!rst && mode_err !== 1'b0) begin
            plain_error(test_idx, "mode_err high without out_valid");
        end
        if (test_idx != idx_q) begin // previous test has drained
            if (idx_q == 3'd3 && outs_by_test[3] != 100) begin
                plain_error(3'd3, $sformatf("burst gave %0d outputs, expected 100", outs_by_test[3]));
            end
            $display("test %s finished: %0d outputs, %0d errors",
                     test_name(idx_q), outs_by_test[idx_q], errs_by_test[idx_q]);
            if (test_idx == 3'd6) begin
                $display("summary: %0d words in, %0d outputs, %0d errors",
                         words_in, outs_total, errors);
            end
            idx_q = test_idx;
        end
        pending = exp_q.size();
    end

endmodule

// File: dv/ecc_sva.sv
module ecc_sva (
    input logic        clk,
    input logic        rst,
    input logic        in_valid,
    input logic [1:0]  in_mode,
    input logic        out_valid,
    input logic [31:0] out_code,
    input logic        mode_err
);

    int fail_count = 0; // failed assertions, read by the testbench

    // every accepted word leaves exactly three edges later
    a_latency: assert property (@(posedge clk) disable iff (rst) in_valid |-> ##3 out_valid)
        else begin
            fail_count++;
            $error("out_valid missing three cycles after in_valid");
        end

    // no output without a matching input
    a_no_extra: assert property (@(posedge clk) disable iff (rst) out_valid |-> $past(in_valid, 3))
        else begin
            fail_count++;
            $error("out_valid without an input three cycles before");
        end

    a_reset: assert property (@(posedge clk) rst |=> (!out_valid && !mode_err && out_code == '0))
        else begin
            fail_count++;
            $error("outputs not cleared one cycle into reset");
        end

    // reserved mode encodes to zero and flags the error
    a_rsvd: assert property (@(posedge clk) disable iff (rst)
            (in_valid && in_mode == 2'b11) |-> ##3 (mode_err && out_code == '0))
        else begin
            fail_count++;
            $error("reserved mode did not give mode_err with a zero codeword");
        end

    a_err_valid: assert property (@(posedge clk) mode_err |-> out_valid)
        else begin
            fail_count++;
            $error("mode_err high while out_valid is low");
        end

endmodule

// File: design/ecc_encoder_top.sv
module ecc_encoder_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             in_valid,  // one word per cycle, no stall
    input  logic [1:0]                       in_mode,
    input  logic [ecc_pkg::INFO_MAX-1:0]     in_info,
    output logic                             out_valid, // in_valid delayed by 3
    output logic [ecc_pkg::CW_WIDTH-1:0]     out_code,
    output logic                             mode_err
);

    import ecc_pkg::*;

    // decode -> execute
    logic                 place_valid;
    ecc_mode_e            place_mode;
    logic [CW_WIDTH-1:0]  place_word;
    logic                 place_err;

    // execute -> result
    logic                 par_valid;
    ecc_mode_e            par_mode;
    logic [CW_WIDTH-1:0]  par_word;
    logic                 par_err;

    // stage 0, mode check and info placement
    info_place info_place_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_mode     (in_mode),
        .in_info     (in_info),
        .place_valid (place_valid),
        .place_mode  (place_mode),
        .place_word  (place_word),
        .place_err   (place_err)
    );

    // stage 1, hamming parity
    parity_gen parity_gen_i (
        .clk         (clk),
        .rst         (rst),
        .place_valid (place_valid),
        .place_mode  (place_mode),
        .place_word  (place_word),
        .place_err   (place_err),
        .par_valid   (par_valid),
        .par_mode    (par_mode),
        .par_word    (par_word),
        .par_err     (par_err)
    );

    // stage 2, overall parity and output register
    enc_stage_2 enc_stage_2_i (
        .clk       (clk),
        .rst       (rst),
        .par_valid (par_valid),
        .par_mode  (par_mode),
        .par_word  (par_word),
        .par_err   (par_err),
        .out_valid (out_valid),
        .out_code  (out_code),
        .mode_err  (mode_err)
    );

endmodule

// File: design/enc_stage_2.sv
module enc_stage_2 (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             par_valid,
    input  ecc_pkg::ecc_mode_e               par_mode,
    input  logic [ecc_pkg::CW_WIDTH-1:0]     par_word,  // bit P-1 still zero
    input  logic                             par_err,
    output logic                             out_valid,
    output logic [ecc_pkg::CW_WIDTH-1:0]     out_code,  // zero-padded extended codeword
    output logic                             mode_err
);

    import ecc_pkg::*;

    localparam int PAD_8_4   = CW_WIDTH - INFO_W_8_4 - PAR_W_8_4;
    localparam int PAD_16_11 = CW_WIDTH - INFO_W_16_11 - PAR_W_16_11;

    logic                 overall; // all-ones row of H times the word
    logic [CW_WIDTH-1:0]  code_d;

    // padding and the empty P-1 slot are zero, so a full reduction is enough
    assign overall = ^par_word;

    // rebuild the codeword with the overall parity at P-1
    always_comb begin
        case (par_mode)
            mode_8_4: begin
                code_d = {{PAD_8_4{1'b0}},
                          par_word[INFO_W_8_4+PAR_W_8_4-1:PAR_W_8_4], // info
                          overall,                                   // index 3
                          par_word[PAR_W_8_4-2:0]};                  // hamming bits
            end
            mode_16_11: begin
                code_d = {{PAD_16_11{1'b0}},
                          par_word[INFO_W_16_11+PAR_W_16_11-1:PAR_W_16_11],
                          overall,                                   // index 4
                          par_word[PAR_W_16_11-2:0]};
            end
            mode_32_26: begin
                code_d = {par_word[CW_WIDTH-1:PAR_W_32_26],          // no padding here
                          overall,                                   // index 5
                          par_word[PAR_W_32_26-2:0]};
            end
            default: begin
                code_d = '0; // reserved mode
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_code  <= '0;
            mode_err  <= 1'b0;
        end else begin
            out_valid <= par_valid;
            out_code  <= code_d;
            mode_err  <= par_err; // lines up with out_valid
        end
    end

endmodule

// File: design/parity_gen.sv
module parity_gen (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             place_valid,
    input  ecc_pkg::ecc_mode_e               place_mode,
    input  logic [ecc_pkg::CW_WIDTH-1:0]     place_word, // info placed, parity field zero
    input  logic                             place_err,
    output logic                             par_valid,
    output ecc_pkg::ecc_mode_e               par_mode,
    output logic [ecc_pkg::CW_WIDTH-1:0]     par_word,   // hamming bits in 0..P-2
    output logic                             par_err
);

    import ecc_pkg::*;

    localparam int NUM_MODES = 3;

    // codeword positions that feed hamming parity bit bit_j
    // info bit k sits at index par_w+k and uses column info_w-1-k
    function automatic logic [CW_WIDTH-1:0] parity_mask(input int par_w, input int info_w,
                                                        input int bit_j);
        logic [CW_WIDTH-1:0] mask;
        logic [PAR_MAX-2:0]  sig;
        mask = '0;
        for (int k = 0; k < info_w; k++) begin
            sig = col_signature(par_w, info_w - 1 - k);
            mask[par_w + k] = sig[bit_j];
        end
        return mask;
    endfunction

    // hamming bits per mode, zero above P-2
    logic [PAR_MAX-2:0] par_bits [NUM_MODES];
    logic [CW_WIDTH-1:0] word_d;

    for (genvar m = 0; m < NUM_MODES; m++) begin : g_mode
        localparam int PW = (m == 0) ? PAR_W_8_4 :
                            (m == 1) ? PAR_W_16_11 : PAR_W_32_26;
        localparam int IW = (m == 0) ? INFO_W_8_4 :
                            (m == 1) ? INFO_W_16_11 : INFO_W_32_26;

        for (genvar j = 0; j < PAR_MAX - 1; j++) begin : g_bit
            if (j < PW - 1) begin : g_used
                localparam logic [CW_WIDTH-1:0] MASK = parity_mask(PW, IW, j);
                assign par_bits[m][j] = ^(place_word & MASK); // one row of H times the word
            end else begin : g_unused
                assign par_bits[m][j] = 1'b0;                 // row not present in this mode
            end
        end
    end

    // drop the parity bits of the active mode into the low field
    always_comb begin
        word_d = place_word;
        case (place_mode)
            mode_8_4: begin
                word_d[PAR_W_8_4-2:0] = par_bits[0][PAR_W_8_4-2:0];
            end
            mode_16_11: begin
                word_d[PAR_W_16_11-2:0] = par_bits[1][PAR_W_16_11-2:0];
            end
            mode_32_26: begin
                word_d[PAR_W_32_26-2:0] = par_bits[2][PAR_W_32_26-2:0];
            end
            default: begin
                word_d = place_word; // reserved word is already zero
            end
        endcase
    end

    // bit P-1 stays zero here, the overall parity comes next stage
    always_ff @(posedge clk) begin
        if (rst) begin
            par_valid <= 1'b0;
            par_mode  <= mode_8_4;
            par_word  <= '0;
            par_err   <= 1'b0;
        end else begin
            par_valid <= place_valid;
            par_mode  <= place_mode;
            par_word  <= word_d;
            par_err   <= place_err;   // forwarded as is, checked only once
        end
    end

endmodule

// File: design/info_place.sv
module info_place (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             in_valid,
    input  logic [1:0]                       in_mode,
    input  logic [ecc_pkg::INFO_MAX-1:0]     in_info,  // right-aligned info bits
    output logic                             place_valid,
    output ecc_pkg::ecc_mode_e               place_mode,
    output logic [ecc_pkg::CW_WIDTH-1:0]     place_word,
    output logic                             place_err   // reserved mode seen on a valid input
);

    import ecc_pkg::*;

    localparam int PAD_8_4   = CW_WIDTH - INFO_W_8_4 - PAR_W_8_4;     // 24 zero bits on top
    localparam int PAD_16_11 = CW_WIDTH - INFO_W_16_11 - PAR_W_16_11; // 16 zero bits on top

    ecc_mode_e            mode_d;
    logic [CW_WIDTH-1:0]  word_d;
    logic                 err_d;

    assign mode_d = ecc_mode_e'(in_mode);
    assign err_d  = in_valid && (mode_d == mode_rsvd); // only flag real inputs

    // info bits go above the parity field, parity field left as zero
    always_comb begin
        case (mode_d)
            mode_8_4: begin
                word_d = {{PAD_8_4{1'b0}},
                          in_info[INFO_W_8_4-1:0],
                          {PAR_W_8_4{1'b0}}};
            end
            mode_16_11: begin
                word_d = {{PAD_16_11{1'b0}},
                          in_info[INFO_W_16_11-1:0],
                          {PAR_W_16_11{1'b0}}};
            end
            mode_32_26: begin
                word_d = {in_info[INFO_W_32_26-1:0],  // fills the whole word
                          {PAR_W_32_26{1'b0}}};
            end
            default: begin
                word_d = '0; // reserved mode, later stages keep it zero
            end
        endcase
    end

    // data loads every cycle, valid qualifies it downstream
    always_ff @(posedge clk) begin
        if (rst) begin
            place_valid <= 1'b0;
            place_mode  <= mode_8_4;
            place_word  <= '0;
            place_err   <= 1'b0;
        end else begin
            place_valid <= in_valid;
            place_mode  <= mode_d;
            place_word  <= word_d;
            place_err   <= err_d;
        end
    end

endmodule

// File: design/ecc_pkg.sv
package ecc_pkg;

    // two-bit mode code from the input port
    typedef enum logic [1:0] {
        mode_8_4   = 2'd0, // 4 info + 4 parity
        mode_16_11 = 2'd1, // 11 info + 5 parity
        mode_32_26 = 2'd2, // 26 info + 6 parity
        mode_rsvd  = 2'd3  // reserved, encodes to zero
    } ecc_mode_e;

    localparam int CW_WIDTH = 32; // padded codeword
    localparam int INFO_MAX = 26; // widest info field
    localparam int PAR_MAX  = 6;  // widest parity field

    localparam int INFO_W_8_4   = 4;
    localparam int INFO_W_16_11 = 11;
    localparam int INFO_W_32_26 = 26;

    localparam int PAR_W_8_4   = 4;
    localparam int PAR_W_16_11 = 5;
    localparam int PAR_W_32_26 = 6;

    // H column of info column col (0 = msb of the info field)
    // the (par_w-1)-bit values with two or more ones, taken largest first
    function automatic logic [PAR_MAX-2:0] col_signature(input int par_w, input int col);
        logic [PAR_MAX-2:0] sig;
        int found;
        int ones;
        sig   = '0;
        found = 0;
        for (int v = (1 << (par_w - 1)) - 1; v >= 0; v--) begin
            ones = 0;
            for (int b = 0; b < par_w - 1; b++) begin
                ones += (v >> b) & 1; // popcount of candidate
            end
            // weight 0 and 1 columns are taken by the parity bits themselves
            if (ones >= 2) begin
                if (found == col) begin
                    sig = v[PAR_MAX-2:0];
                end
                found++;
            end
        end
        return sig;
    endfunction

endpackage
